//--- source/dmem_wb_pkg.sv
// Shared codes, widths and the bus word view for the data-memory bridge
// Bus is fixed at 32 bits with four byte selects
// Width code 3 is not a legal core code and is handled as a word
// Response codes follow the core handshake and NOTRDY is the idle value

package dmem_wb_pkg;

    // ----------------------------------------
    // Bus geometry
    // ----------------------------------------
    localparam int unsigned WB_WIDTH = 32;
    localparam int unsigned WB_SEL_W = 4;

    // ----------------------------------------
    // Core request encodings
    // ----------------------------------------
    // Access width code
    localparam int unsigned MEM_WIDTH_W = 2;
    localparam logic [MEM_WIDTH_W-1:0] MEM_WIDTH_BYTE  = 2'd0;
    localparam logic [MEM_WIDTH_W-1:0] MEM_WIDTH_HWORD = 2'd1;
    localparam logic [MEM_WIDTH_W-1:0] MEM_WIDTH_WORD  = 2'd2;

    // Command bit
    localparam logic MEM_CMD_RD = 1'b0;
    localparam logic MEM_CMD_WR = 1'b1;

    // ----------------------------------------
    // Core response encodings
    // ----------------------------------------
    localparam int unsigned MEM_RESP_W = 2;
    localparam logic [MEM_RESP_W-1:0] MEM_RESP_NOTRDY = 2'd0;
    localparam logic [MEM_RESP_W-1:0] MEM_RESP_RDY_OK = 2'd1;
    localparam logic [MEM_RESP_W-1:0] MEM_RESP_RDY_ER = 2'd2;

    // Request queue size, set by the bus pipelining
    localparam int unsigned REQ_FIFO_DEPTH = 2;

    // One bus word, seen whole or by lanes
    // Lane 0 is the least significant byte or halfword
    typedef union packed {
        logic [WB_WIDTH-1:0]  word;
        logic [3:0][7:0]      lanes_b;
        logic [1:0][15:0]     lanes_h;
    } wb_word_u;

endpackage

//--- source/dmem_req_align.sv
// Lane steering of one core request onto the 32-bit bus
// Purely combinational, no handshake is seen here
// Misaligned halfwords are not detected, address bit 0 is ignored for them
// Width code 3 behaves as a full word

`timescale 1ns/1ns

module dmem_req_align (
    // Core request fields
    input  logic                                dmem_cmd_i,
    input  logic [dmem_wb_pkg::MEM_WIDTH_W-1:0] dmem_width_i,
    input  logic [dmem_wb_pkg::WB_WIDTH-1:0]    dmem_addr_i,
    input  logic [dmem_wb_pkg::WB_WIDTH-1:0]    dmem_wdata_i,

    // Bus-side view of the request
    output logic                                req_we_o,
    output dmem_wb_pkg::wb_word_u               req_wdata_o,
    output logic [dmem_wb_pkg::WB_SEL_W-1:0]    req_sel_o
);

    // ----------------------------------------
    // Local signals
    // ----------------------------------------
    // Byte offset inside the word
    logic [1:0] byte_ofs;
    // Halfword lane index
    logic       hword_ofs;

    assign byte_ofs  = dmem_addr_i[1:0];
    assign hword_ofs = dmem_addr_i[1];

    // Write flag straight from the command bit
    assign req_we_o = (dmem_cmd_i == dmem_wb_pkg::MEM_CMD_WR);

    // ----------------------------------------
    // Write data lane steering
    // ----------------------------------------
    always_comb begin
        // Unused lanes stay zero
        req_wdata_o.word = '0;
        case (dmem_width_i)
            dmem_wb_pkg::MEM_WIDTH_BYTE: begin
                // Low byte of core data into the addressed lane
                req_wdata_o.lanes_b[byte_ofs] = dmem_wdata_i[7:0];
            end
            dmem_wb_pkg::MEM_WIDTH_HWORD: begin
                // Low halfword into upper or lower lane
                req_wdata_o.lanes_h[hword_ofs] = dmem_wdata_i[15:0];
            end
            default: begin
                // Word and the spare code
                req_wdata_o.word = dmem_wdata_i;
            end
        endcase
    end

    // ----------------------------------------
    // Byte select generation
    // ----------------------------------------
    always_comb begin
        case (dmem_width_i)
            dmem_wb_pkg::MEM_WIDTH_BYTE: begin
                // One select bit at the byte offset
                req_sel_o = 4'b0001 << byte_ofs;
            end
            dmem_wb_pkg::MEM_WIDTH_HWORD: begin
                // Two adjacent bits, lower or upper pair
                req_sel_o = 4'b0011 << {hword_ofs, 1'b0};
            end
            default: begin
                // All lanes
                req_sel_o = '1;
            end
        endcase
    end

endmodule

//--- source/dmem_req_fifo.sv
// Two-entry request queue between core and Wishbone strobe
// Head is read combinationally, one cycle after the write edge
// Writer must not push while full, the top level gates this
// Storage has no reset, only pointers and count do

`timescale 1ns/1ns

module dmem_req_fifo (
    input  logic                                clk,
    input  logic                                rst_n,

    // Push and pop strobes
    input  logic                                wr_en_i,
    input  logic                                rd_en_i,

    // Entry being pushed
    input  logic                                wr_we_i,
    input  logic [dmem_wb_pkg::MEM_WIDTH_W-1:0] wr_width_i,
    input  logic [dmem_wb_pkg::WB_WIDTH-1:0]    wr_addr_i,
    input  dmem_wb_pkg::wb_word_u               wr_wdata_i,
    input  logic [dmem_wb_pkg::WB_SEL_W-1:0]    wr_sel_i,

    // Head entry
    output logic                                rd_we_o,
    output logic [dmem_wb_pkg::MEM_WIDTH_W-1:0] rd_width_o,
    output logic [dmem_wb_pkg::WB_WIDTH-1:0]    rd_addr_o,
    output dmem_wb_pkg::wb_word_u               rd_wdata_o,
    output logic [dmem_wb_pkg::WB_SEL_W-1:0]    rd_sel_o,

    // Occupancy flags
    output logic                                full_o,
    output logic                                empty_o
);

    localparam int unsigned DEPTH = dmem_wb_pkg::REQ_FIFO_DEPTH;
    localparam int unsigned PTR_W = $clog2(DEPTH);
    localparam int unsigned CNT_W = $clog2(DEPTH + 1);

    // ----------------------------------------
    // Storage and pointers
    // ----------------------------------------
    logic                                mem_we    [DEPTH];
    logic [dmem_wb_pkg::MEM_WIDTH_W-1:0] mem_width [DEPTH];
    logic [dmem_wb_pkg::WB_WIDTH-1:0]    mem_addr  [DEPTH];
    dmem_wb_pkg::wb_word_u               mem_wdata [DEPTH];
    logic [dmem_wb_pkg::WB_SEL_W-1:0]    mem_sel   [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    // Entry write, payload only
    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem_we[wr_ptr]    <= wr_we_i;
            mem_width[wr_ptr] <= wr_width_i;
            mem_addr[wr_ptr]  <= wr_addr_i;
            mem_wdata[wr_ptr] <= wr_wdata_i;
            mem_sel[wr_ptr]   <= wr_sel_i;
        end
    end

    // Pointer and count update
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            // Wrap at the last entry
            if (wr_en_i) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + PTR_W'(1);
            end
            if (rd_en_i) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + PTR_W'(1);
            end
            // Simultaneous push and pop keeps the count
            case ({wr_en_i, rd_en_i})
                2'b10:   count <= count + CNT_W'(1);
                2'b01:   count <= count - CNT_W'(1);
                default: count <= count;
            endcase
        end
    end

    // ----------------------------------------
    // Head and flags
    // ----------------------------------------
    assign rd_we_o    = mem_we[rd_ptr];
    assign rd_width_o = mem_width[rd_ptr];
    assign rd_addr_o  = mem_addr[rd_ptr];
    assign rd_wdata_o = mem_wdata[rd_ptr];
    assign rd_sel_o   = mem_sel[rd_ptr];

    assign full_o  = (count == CNT_W'(DEPTH));
    assign empty_o = (count == '0);

endmodule

//--- source/dmem_wb_port.sv
// Wishbone master side of the bridge and the registered core response
// One response per acknowledged head, one cycle after wbd_ack_i
// An acknowledge with an empty queue is ignored
// Error responses and write responses carry zero read data

`timescale 1ns/1ns

module dmem_wb_port (
    input  logic                                clk,
    input  logic                                rst_n,

    // Queue head
    input  logic                                head_we_i,
    input  logic [dmem_wb_pkg::MEM_WIDTH_W-1:0] head_width_i,
    input  logic [dmem_wb_pkg::WB_WIDTH-1:0]    head_addr_i,
    input  dmem_wb_pkg::wb_word_u               head_wdata_i,
    input  logic [dmem_wb_pkg::WB_SEL_W-1:0]    head_sel_i,
    input  logic                                empty_i,
    output logic                                pop_o,

    // Wishbone master
    output logic                                wbd_stb_o,
    output logic [dmem_wb_pkg::WB_WIDTH-1:0]    wbd_adr_o,
    output logic                                wbd_we_o,
    output logic [dmem_wb_pkg::WB_WIDTH-1:0]    wbd_dat_o,
    output logic [dmem_wb_pkg::WB_SEL_W-1:0]    wbd_sel_o,
    input  logic [dmem_wb_pkg::WB_WIDTH-1:0]    wbd_dat_i,
    input  logic                                wbd_ack_i,
    input  logic                                wbd_err_i,

    // Core response
    output logic [dmem_wb_pkg::MEM_RESP_W-1:0]  dmem_resp_o,
    output logic [dmem_wb_pkg::WB_WIDTH-1:0]    dmem_rdata_o
);

    // ----------------------------------------
    // Response registers
    // ----------------------------------------
    // Response valid, the only control bit
    logic                                resp_vld_q;
    logic                                resp_err_q;
    logic [dmem_wb_pkg::MEM_WIDTH_W-1:0] resp_width_q;
    logic [1:0]                          resp_addr_q;
    dmem_wb_pkg::wb_word_u               resp_rdata_q;

    // ----------------------------------------
    // Bus drive from the head
    // ----------------------------------------
    // Strobe held while anything is queued
    assign wbd_stb_o = ~empty_i;

    // Zeros when idle so stale entries never reach the bus
    assign wbd_adr_o = empty_i ? '0 : head_addr_i;
    assign wbd_we_o  = empty_i ? 1'b0 : head_we_i;
    assign wbd_dat_o = empty_i ? '0 : head_wdata_i.word;
    assign wbd_sel_o = empty_i ? '0 : head_sel_i;

    // Head completes on acknowledge
    assign pop_o = wbd_ack_i & ~empty_i;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            resp_vld_q <= 1'b0;
        end else begin
            resp_vld_q <= pop_o;
        end
    end

    // Capture of the completed transfer
    always_ff @(posedge clk) begin
        if (pop_o) begin
            resp_err_q   <= wbd_err_i;
            resp_width_q <= head_width_i;
            resp_addr_q  <= head_addr_i[1:0];
            // Bus data only counts for a good read
            resp_rdata_q.word <= (head_we_i | wbd_err_i) ? '0 : wbd_dat_i;
        end
    end

    // ----------------------------------------
    // Core response output
    // ----------------------------------------
    always_comb begin
        if (!resp_vld_q) begin
            dmem_resp_o = dmem_wb_pkg::MEM_RESP_NOTRDY;
        end else if (resp_err_q) begin
            dmem_resp_o = dmem_wb_pkg::MEM_RESP_RDY_ER;
        end else begin
            dmem_resp_o = dmem_wb_pkg::MEM_RESP_RDY_OK;
        end
    end

    // Lane extraction, zero-filled to the left
    always_comb begin
        dmem_rdata_o = '0;
        if (resp_vld_q) begin
            case (resp_width_q)
                dmem_wb_pkg::MEM_WIDTH_BYTE: begin
                    dmem_rdata_o[7:0] = resp_rdata_q.lanes_b[resp_addr_q];
                end
                dmem_wb_pkg::MEM_WIDTH_HWORD: begin
                    dmem_rdata_o[15:0] = resp_rdata_q.lanes_h[resp_addr_q[1]];
                end
                default: begin
                    dmem_rdata_o = resp_rdata_q.word;
                end
            endcase
        end
    end

endmodule

//--- source/dmem_wb_bridge.sv
// Data-memory port to Wishbone master bridge, top level
// Up to two requests in flight, responses return in order
// Core must take every response, there is no response stall

`timescale 1ns/1ns

module dmem_wb_bridge (
    input  logic                                clk,
    input  logic                                rst_n,

    // Core request
    input  logic                                dmem_req_i,
    input  logic                                dmem_cmd_i,
    input  logic [dmem_wb_pkg::MEM_WIDTH_W-1:0] dmem_width_i,
    input  logic [dmem_wb_pkg::WB_WIDTH-1:0]    dmem_addr_i,
    input  logic [dmem_wb_pkg::WB_WIDTH-1:0]    dmem_wdata_i,
    output logic                                dmem_req_ack_o,

    // Core response
    output logic [dmem_wb_pkg::MEM_RESP_W-1:0]  dmem_resp_o,
    output logic [dmem_wb_pkg::WB_WIDTH-1:0]    dmem_rdata_o,

    // Wishbone master
    output logic                                wbd_stb_o,
    output logic [dmem_wb_pkg::WB_WIDTH-1:0]    wbd_adr_o,
    output logic                                wbd_we_o,
    output logic [dmem_wb_pkg::WB_WIDTH-1:0]    wbd_dat_o,
    output logic [dmem_wb_pkg::WB_SEL_W-1:0]    wbd_sel_o,
    input  logic [dmem_wb_pkg::WB_WIDTH-1:0]    wbd_dat_i,
    input  logic                                wbd_ack_i,
    input  logic                                wbd_err_i
);

    // ----------------------------------------
    // Internal wires
    // ----------------------------------------
    // Aligned request
    logic                                req_we;
    dmem_wb_pkg::wb_word_u               req_wdata;
    logic [dmem_wb_pkg::WB_SEL_W-1:0]    req_sel;

    // Queue head and control
    logic                                head_we;
    logic [dmem_wb_pkg::MEM_WIDTH_W-1:0] head_width;
    logic [dmem_wb_pkg::WB_WIDTH-1:0]    head_addr;
    dmem_wb_pkg::wb_word_u               head_wdata;
    logic [dmem_wb_pkg::WB_SEL_W-1:0]    head_sel;
    logic                                fifo_full;
    logic                                fifo_empty;
    logic                                fifo_pop;
    logic                                req_accept;

    // Accept while a slot is free
    assign dmem_req_ack_o = ~fifo_full;
    assign req_accept     = dmem_req_i & ~fifo_full;

    dmem_req_align u_req_align (
        .dmem_cmd_i   (dmem_cmd_i),
        .dmem_width_i (dmem_width_i),
        .dmem_addr_i  (dmem_addr_i),
        .dmem_wdata_i (dmem_wdata_i),
        .req_we_o     (req_we),
        .req_wdata_o  (req_wdata),
        .req_sel_o    (req_sel)
    );

    // Width and address stored raw for the read lane pick
    dmem_req_fifo u_req_fifo (
        .clk        (clk),
        .rst_n      (rst_n),
        .wr_en_i    (req_accept),
        .rd_en_i    (fifo_pop),
        .wr_we_i    (req_we),
        .wr_width_i (dmem_width_i),
        .wr_addr_i  (dmem_addr_i),
        .wr_wdata_i (req_wdata),
        .wr_sel_i   (req_sel),
        .rd_we_o    (head_we),
        .rd_width_o (head_width),
        .rd_addr_o  (head_addr),
        .rd_wdata_o (head_wdata),
        .rd_sel_o   (head_sel),
        .full_o     (fifo_full),
        .empty_o    (fifo_empty)
    );

    dmem_wb_port u_wb_port (
        .clk          (clk),
        .rst_n        (rst_n),
        .head_we_i    (head_we),
        .head_width_i (head_width),
        .head_addr_i  (head_addr),
        .head_wdata_i (head_wdata),
        .head_sel_i   (head_sel),
        .empty_i      (fifo_empty),
        .pop_o        (fifo_pop),
        .wbd_stb_o    (wbd_stb_o),
        .wbd_adr_o    (wbd_adr_o),
        .wbd_we_o     (wbd_we_o),
        .wbd_dat_o    (wbd_dat_o),
        .wbd_sel_o    (wbd_sel_o),
        .wbd_dat_i    (wbd_dat_i),
        .wbd_ack_i    (wbd_ack_i),
        .wbd_err_i    (wbd_err_i),
        .dmem_resp_o  (dmem_resp_o),
        .dmem_rdata_o (dmem_rdata_o)
    );

endmodule

//--- test/wb_slave_model.sv
// Wishbone memory slave for the bridge testbench
// 16 words at address bits 5:2, the other low bits are ignored
// Acknowledge comes after 0 to 3 idle cycles of strobe, one transfer at a time
// Addresses with top nibble F answer with error and leave memory untouched

`timescale 1ns/1ns

module wb_slave_model (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        stb_i,
    input  logic [31:0] adr_i,
    input  logic        we_i,
    input  logic [31:0] dat_i,
    input  logic [3:0]  sel_i,
    output logic [31:0] dat_o,
    output logic        ack_o,
    output logic        err_o
);

    localparam int unsigned SEED       = 14093;
    localparam logic [3:0]  ERR_NIBBLE = 4'hF;

    logic [31:0] mem [16];
    int unsigned idle_left;

    initial begin
        void'($urandom(SEED));
        dat_o     = '0;
        ack_o     = 1'b0;
        err_o     = 1'b0;
        idle_left = $urandom % 4;
        // Fill differs in every word
        for (int i = 0; i < 16; i++) begin
            mem[i] = {4{4'hA, 4'(i)}};
        end
        forever begin
            @(posedge clk);
            if (!rst_n) begin
                ack_o <= 1'b0;
                err_o <= 1'b0;
                dat_o <= '0;
            end else if (ack_o) begin
                // Transfer closes on this edge, next one gets a fresh delay
                ack_o     <= 1'b0;
                err_o     <= 1'b0;
                dat_o     <= '0;
                idle_left = $urandom % 4;
            end else if (stb_i && idle_left != 0) begin
                idle_left--;
            end else if (stb_i) begin
                ack_o <= 1'b1;
                if (adr_i[31:28] == ERR_NIBBLE) begin
                    // Junk on the data lines, the bridge must drop it
                    err_o <= 1'b1;
                    dat_o <= 32'hDEAD_BEEF;
                end else if (we_i) begin
                    // Old word on the data lines, a write response must not show it
                    dat_o <= mem[adr_i[5:2]];
                    for (int b = 0; b < 4; b++) begin
                        if (sel_i[b]) begin
                            mem[adr_i[5:2]][8*b +: 8] = dat_i[8*b +: 8];
                        end
                    end
                end else begin
                    dat_o <= mem[adr_i[5:2]];
                end
            end
        end
    end

endmodule

//--- test/dmem_wb_bridge_tb.sv
// Testbench for the data-memory to Wishbone bridge
// Table entries stream back to back, each response is scored against its entry
// Slave delays are random, so order and data are checked rather than latency
// Run ends after 20 cycles per entry plus 100

`timescale 1ns/1ns

module dmem_wb_bridge_tb;

    typedef struct {
        string                               name;
        logic                                cmd;
        logic [dmem_wb_pkg::MEM_WIDTH_W-1:0] width;
        logic [dmem_wb_pkg::WB_WIDTH-1:0]    addr;
        logic [dmem_wb_pkg::WB_WIDTH-1:0]    wdata;
        logic [dmem_wb_pkg::MEM_RESP_W-1:0]  resp;
        dmem_wb_pkg::wb_word_u               rdata;
    } entry_t;

    logic                                clk;
    logic                                rst_n;
    logic                                dmem_req;
    logic                                dmem_cmd;
    logic [dmem_wb_pkg::MEM_WIDTH_W-1:0] dmem_width;
    logic [dmem_wb_pkg::WB_WIDTH-1:0]    dmem_addr;
    logic [dmem_wb_pkg::WB_WIDTH-1:0]    dmem_wdata;
    logic                                dmem_req_ack;
    logic [dmem_wb_pkg::MEM_RESP_W-1:0]  dmem_resp;
    logic [dmem_wb_pkg::WB_WIDTH-1:0]    dmem_rdata;
    logic                                wbd_stb;
    logic [dmem_wb_pkg::WB_WIDTH-1:0]    wbd_adr;
    logic                                wbd_we;
    logic [dmem_wb_pkg::WB_WIDTH-1:0]    wbd_dat_w;
    logic [dmem_wb_pkg::WB_SEL_W-1:0]    wbd_sel;
    logic [dmem_wb_pkg::WB_WIDTH-1:0]    wbd_dat_r;
    logic                                wbd_ack;
    logic                                wbd_err;

    entry_t table_q[$];
    int     err_count = 0;
    int     test_pass = 0;
    int     test_fail = 0;

    // ----------------------------------------
    // DUT and slave
    // ----------------------------------------
    dmem_wb_bridge uut (
        .clk(clk), .rst_n(rst_n),
        .dmem_req_i(dmem_req), .dmem_cmd_i(dmem_cmd), .dmem_width_i(dmem_width),
        .dmem_addr_i(dmem_addr), .dmem_wdata_i(dmem_wdata), .dmem_req_ack_o(dmem_req_ack),
        .dmem_resp_o(dmem_resp), .dmem_rdata_o(dmem_rdata),
        .wbd_stb_o(wbd_stb), .wbd_adr_o(wbd_adr), .wbd_we_o(wbd_we), .wbd_dat_o(wbd_dat_w),
        .wbd_sel_o(wbd_sel), .wbd_dat_i(wbd_dat_r), .wbd_ack_i(wbd_ack), .wbd_err_i(wbd_err)
    );

    wb_slave_model u_slave (
        .clk(clk), .rst_n(rst_n), .stb_i(wbd_stb), .adr_i(wbd_adr), .we_i(wbd_we),
        .dat_i(wbd_dat_w), .sel_i(wbd_sel), .dat_o(wbd_dat_r), .ack_o(wbd_ack), .err_o(wbd_err)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ----------------------------------------
    // Table and checks
    // ----------------------------------------
    // Size in bytes, write flag and error flag map onto the core codes
    task automatic push_entry(input string name, input bit wr, input int size,
                              input logic [31:0] addr, input logic [31:0] wdata,
                              input bit err, input logic [31:0] rdata);
        entry_t e;
        e.name  = name;
        e.cmd   = wr ? dmem_wb_pkg::MEM_CMD_WR : dmem_wb_pkg::MEM_CMD_RD;
        e.width = (size == 1) ? dmem_wb_pkg::MEM_WIDTH_BYTE :
                  (size == 2) ? dmem_wb_pkg::MEM_WIDTH_HWORD : dmem_wb_pkg::MEM_WIDTH_WORD;
        e.addr  = addr;
        e.wdata = wdata;
        e.resp  = err ? dmem_wb_pkg::MEM_RESP_RDY_ER : dmem_wb_pkg::MEM_RESP_RDY_OK;
        e.rdata.word = rdata;
        table_q.push_back(e);
    endtask

    task automatic check_resp(input string sig, input logic [dmem_wb_pkg::MEM_RESP_W-1:0] got,
                              input logic [dmem_wb_pkg::MEM_RESP_W-1:0] exp);
        if (got !== exp) begin
            $display("Fail at %0t ns: %s is %0d, expected %0d", $time, sig, got, exp);
            err_count++;
        end
    endtask

    task automatic check_word(input string sig, input dmem_wb_pkg::wb_word_u got,
                              input dmem_wb_pkg::wb_word_u exp);
        if (got.word !== exp.word) begin
            $display("Fail at %0t ns: %s is %h, expected %h", $time, sig, got.word, exp.word);
            err_count++;
        end
    endtask

    // Bus lines are all zero while the strobe is low
    task automatic check_bus_idle();
        check_word("wbd_adr_o", wbd_adr, 32'h0);
        check_word("wbd_dat_o", wbd_dat_w, 32'h0);
        if (wbd_we !== 1'b0) begin
            $display("Fail at %0t ns: wbd_we_o is %b, expected 0", $time, wbd_we);
            err_count++;
        end
        if (wbd_sel !== 4'b0000) begin
            $display("Fail at %0t ns: wbd_sel_o is %b, expected 0000", $time, wbd_sel);
            err_count++;
        end
    endtask

    task automatic report_test(input int num, input string name, input bit ok);
        $display("Test %0d %s: %s", num, name, ok ? "pass" : "error");
        if (ok) begin
            test_pass++;
        end else begin
            test_fail++;
        end
    endtask

    task automatic score_response(input int idx);
        int errs_before;
        errs_before = err_count;
        check_resp("dmem_resp_o", dmem_resp, table_q[idx].resp);
        check_word("dmem_rdata_o", dmem_rdata, table_q[idx].rdata);
        report_test(idx + 1, table_q[idx].name, err_count == errs_before);
    endtask

    task automatic drive_request(input entry_t e);
        dmem_req   = 1'b1;
        dmem_cmd   = e.cmd;
        dmem_width = e.width;
        dmem_addr  = e.addr;
        dmem_wdata = e.wdata;
    endtask

    task automatic drive_idle();
        dmem_req   = 1'b0;
        dmem_cmd   = dmem_wb_pkg::MEM_CMD_RD;
        dmem_width = dmem_wb_pkg::MEM_WIDTH_BYTE;
        dmem_addr  = '0;
        dmem_wdata = '0;
    endtask

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------
    initial begin
        int n;
        int limit;
        int issued;
        int done;
        int cycles;
        int errs_before;
        bit taking;
        bit stalled;
        bit timed_out;
        rst_n = 1'b0;
        drive_idle();

        push_entry("word write",           1, 4, 32'h00, 32'h1234_5678, 0, 32'h0);
        push_entry("word read back",       0, 4, 32'h00, 32'h0,         0, 32'h1234_5678);
        push_entry("byte write ofs 0",     1, 1, 32'h04, 32'hFFFF_FF5A, 0, 32'h0);
        push_entry("byte write ofs 1",     1, 1, 32'h05, 32'h0000_00B2, 0, 32'h0);
        push_entry("byte write ofs 2",     1, 1, 32'h06, 32'h0000_00C3, 0, 32'h0);
        push_entry("byte write ofs 3",     1, 1, 32'h07, 32'h0000_00D4, 0, 32'h0);
        push_entry("byte read ofs 0",      0, 1, 32'h04, 32'h0,         0, 32'h0000_005A);
        push_entry("byte read ofs 1",      0, 1, 32'h05, 32'h0,         0, 32'h0000_00B2);
        push_entry("byte read ofs 2",      0, 1, 32'h06, 32'h0,         0, 32'h0000_00C3);
        push_entry("byte read ofs 3",      0, 1, 32'h07, 32'h0,         0, 32'h0000_00D4);
        push_entry("word of bytes",        0, 4, 32'h04, 32'h0,         0, 32'hD4C3_B25A);
        push_entry("hword write ofs 0",    1, 2, 32'h08, 32'h5555_BEEF, 0, 32'h0);
        push_entry("hword write ofs 2",    1, 2, 32'h0A, 32'h0000_CAFE, 0, 32'h0);
        push_entry("hword read ofs 0",     0, 2, 32'h08, 32'h0,         0, 32'h0000_BEEF);
        push_entry("hword read ofs 2",     0, 2, 32'h0A, 32'h0,         0, 32'h0000_CAFE);
        push_entry("error region read",    0, 4, 32'hF000_0010, 32'h0,  1, 32'h0);
        push_entry("error region write",   1, 4, 32'hF000_0014, 32'h1,  1, 32'h0);
        push_entry("read after error",     0, 4, 32'h08, 32'h0,         0, 32'hCAFE_BEEF);
        push_entry("queued word write",    1, 4, 32'h0C, 32'h0BAD_F00D, 0, 32'h0);
        push_entry("queued word read",     0, 4, 32'h0C, 32'h0,         0, 32'h0BAD_F00D);
        push_entry("queued byte read",     0, 1, 32'h0F, 32'h0,         0, 32'h0000_000B);

        n         = table_q.size();
        limit     = n * 20 + 100;
        issued    = 0;
        done      = 0;
        cycles    = 0;
        taking    = 1'b0;
        stalled   = 1'b0;

        repeat (3) @(negedge clk);
        rst_n = 1'b1;

        // Idle state straight after reset
        @(negedge clk);
        errs_before = err_count;
        check_resp("dmem_resp_o", dmem_resp, dmem_wb_pkg::MEM_RESP_NOTRDY);
        check_word("dmem_rdata_o", dmem_rdata, 32'h0);
        if (dmem_req_ack !== 1'b1) begin
            $display("Fail at %0t ns: dmem_req_ack_o is %b, expected 1", $time, dmem_req_ack);
            err_count++;
        end
        if (wbd_stb !== 1'b0) begin
            $display("Fail at %0t ns: wbd_stb_o is %b, expected 0", $time, wbd_stb);
            err_count++;
        end
        check_bus_idle();
        report_test(0, "reset state", err_count == errs_before);

        // Requests issue as fast as the bridge takes them
        while (done < n && cycles < limit) begin
            @(negedge clk);
            cycles++;
            // Accepted on the rising edge just passed
            if (taking) begin
                issued++;
            end
            if (dmem_resp !== dmem_wb_pkg::MEM_RESP_NOTRDY) begin
                if (done >= issued) begin
                    $display("Error at %0t ns: response with no request pending", $time);
                    err_count++;
                end else begin
                    score_response(done);
                    done++;
                end
            end else begin
                // No response, no data
                check_word("dmem_rdata_o", dmem_rdata, 32'h0);
            end
            if (!wbd_stb) begin
                check_bus_idle();
            end
            if (issued < n) begin
                drive_request(table_q[issued]);
            end else begin
                drive_idle();
            end
            // Acknowledge only moves on rising edges, so it is settled here
            taking = dmem_req && dmem_req_ack;
            if (dmem_req && !dmem_req_ack) begin
                stalled = 1'b1;
            end
            if (taking && (issued - done) >= dmem_wb_pkg::REQ_FIFO_DEPTH) begin
                $display("Error at %0t ns: third request taken before a response", $time);
                err_count++;
            end
        end

        timed_out = (done < n);
        if (timed_out) begin
            $display("Timeout: %0d of %0d responses after %0d cycles", done, n, cycles);
        end
        if (!stalled) begin
            $display("Error: request acknowledge never dropped with two requests queued");
            err_count++;
        end
        $display("Summary: %0d run, %0d passed, %0d failed, %0d errors",
                 test_pass + test_fail, test_pass, test_fail, err_count);
        if (err_count == 0 && !timed_out) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- verilog.f
source/dmem_wb_pkg.sv
source/dmem_req_align.sv
source/dmem_req_fifo.sv
source/dmem_wb_port.sv
source/dmem_wb_bridge.sv
test/wb_slave_model.sv
test/dmem_wb_bridge_tb.sv

//--- Makefile
# Verilator build and run of the data-memory to Wishbone bridge testbench
# Every variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= dmem_wb_bridge_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal
FAIL_MSG  ?= tests failed

SOURCES := $(wildcard source/*.sv) $(wildcard test/*.sv)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator, run, and scan $(LOG) for the fail message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS FAIL_MSG"

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation reported failure, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q "all tests passed" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; \
		exit 1; \
	fi
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
